// ==== qs_top.f ====
hdl/qs_pkg.sv
hdl/qs_bank_pkg.sv
hdl/qs_bank_if.sv
hdl/qs_enq.sv
hdl/qs_banks.sv
hdl/qs_sort_deq.sv
hdl/qs_top.sv
tests/qs_top_sva.sv
tests/tb_qs_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_qs_top
FILELIST := qs_top.f

BIN      := obj_dir/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== tests/qs_golden.txt ====
// Columns: kind nibble (0 input, 1 expected output), eop nibble, 16-bit word
// Each input packet is followed by its sorted output, packets in arrival order
014242
114242
00ffff
008001
007fff
001234
000100
0000ff
000001
010000
100000
100001
1000ff
100100
101234
107fff
108001
11ffff
008000
000003
008000
010001
100001
100003
108000
118000
000010
000020
010030
100010
100020
110030

// ==== tests/tb_qs_top.sv ====
// Sorter testbench; reads tests/qs_golden.txt from the project root, up to 64 lines
`timescale 1ns/1ps

module tb_qs_top;

  logic        clk;
  logic        rst_n;
  logic        in_vld;
  logic        in_sop;
  logic        in_eop;
  qs_pkg::w_t  in_dat;
  logic        in_rdy;
  logic        out_vld;
  logic        out_sop;
  logic        out_eop;
  qs_pkg::w_t  out_dat;
  logic        out_rdy;

  // Raw file image before the split by kind
  logic [23:0] golden [0:63];
  // Bit 17 is sop and bit 16 eop above the data word
  logic [17:0] in_q  [$];
  logic [17:0] exp_q [$];
  int          n_lines;
  bit          loaded;

  qs_top #(.BANK_N(8)) u_qs_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_vld  (in_vld),
    .in_sop  (in_sop),
    .in_eop  (in_eop),
    .in_dat  (in_dat),
    .in_rdy  (in_rdy),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_dat (out_dat),
    .out_rdy (out_rdy)
  );

  bind qs_top qs_top_sva u_qs_top_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_rdy  (in_rdy),
    .out_vld (out_vld),
    .out_rdy (out_rdy),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_dat (out_dat)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
    if (act !== exp) begin
      $display("ERR %0t: %s mismatch, got %0h expected %0h", $time, what, act, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Seeding and idle inputs before the golden file is split into queues
  initial begin : load_golden
    logic first_in;
    logic first_out;
    void'($urandom(32'hcb3b));
    clk     = 1'b0;
    rst_n   <= 1'b0;
    in_vld  <= 1'b0;
    in_sop  <= 1'b0;
    in_eop  <= 1'b0;
    in_dat  <= '0;
    out_rdy <= 1'b0;
    // Kind F marks unused entries
    for (int i = 0; i < 64; i++) begin
      golden[i] = {4'hf, 20'(i)};
    end
    $readmemh("tests/qs_golden.txt", golden);
    n_lines   = 0;
    first_in  = 1'b1;
    first_out = 1'b1;
    for (int i = 0; i < 64; i++) begin
      if (golden[i][23:20] == 4'h0) begin
        in_q.push_back({first_in, golden[i][16], golden[i][15:0]});
        first_in = golden[i][16];
        n_lines++;
      end else if (golden[i][23:20] == 4'h1) begin
        exp_q.push_back({first_out, golden[i][16], golden[i][15:0]});
        first_out = golden[i][16];
        n_lines++;
      end
    end
    loaded = 1'b1;
  end

  // Reset release and input words with random gaps
  initial begin : drive_inputs
    int k;
    k = 0;
    wait (loaded);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (k < in_q.size()) begin
      @(posedge clk);
      // Word taken at this edge
      if (in_vld && in_rdy) begin
        k++;
      end
      if (k < in_q.size() && ($urandom % 4) != 0) begin
        in_vld <= 1'b1;
        in_sop <= in_q[k][17];
        in_eop <= in_q[k][16];
        in_dat <= in_q[k][15:0];
      end else begin
        in_vld <= 1'b0;
      end
    end
  end

  // Output compare and out_rdy pattern
  initial begin : check_outputs
    int m;
    int stall;
    int extra;
    m     = 0;
    extra = 0;
    // Long opening stall fills both banks
    stall = 150;
    wait (loaded);
    wait (rst_n);
    while (m < exp_q.size()) begin
      @(posedge clk);
      if (out_vld && out_rdy) begin
        check_eq(32'(out_dat), 32'(exp_q[m][15:0]), "out_dat");
        check_eq(32'(out_sop), 32'(exp_q[m][17]), "out_sop");
        check_eq(32'(out_eop), 32'(exp_q[m][16]), "out_eop");
        m++;
      end
      if (stall > 0) begin
        stall--;
        out_rdy <= 1'b0;
      end else if (($urandom % 64) == 0) begin
        stall = 40;
        out_rdy <= 1'b0;
      end else begin
        out_rdy <= ($urandom % 4) != 0;
      end
    end
    // Nothing may follow the last packet
    out_rdy <= 1'b1;
    repeat (20) begin
      @(posedge clk);
      if (out_vld && out_rdy) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("Output produced %0d words beyond the expected data", extra);
      $display("TESTBENCH FAILED");
      $fatal(1, "extra output words");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  // Budget of 200 cycles per golden line
  initial begin : watchdog
    wait (loaded);
    repeat (n_lines * 200) @(posedge clk);
    $display("Run timed out after %0d cycles without all outputs", n_lines * 200);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== tests/qs_top_sva.sv ====
// Handshake checks bound to qs_top; a synchronous reset is assumed
`timescale 1ns/1ps

module qs_top_sva (
  input logic       clk,
  input logic       rst_n,
  input logic       in_rdy,
  input logic       out_vld,
  input logic       out_rdy,
  input logic       out_sop,
  input logic       out_eop,
  input qs_pkg::w_t out_dat
);

  // Set while a packet is open on the output
  logic in_pkt_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_pkt_r <= 1'b0;
    end else if (out_vld && out_rdy) begin
      in_pkt_r <= !out_eop;
    end
  end

  // Valid held until taken
  a_vld_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld && !out_rdy |=> out_vld)
    else $error("out_vld dropped before out_rdy");

  // Stalled beat keeps its fields
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld && !out_rdy |=> $stable(out_dat) && $stable(out_sop) && $stable(out_eop))
    else $error("output fields changed during a stall");

  // Quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !in_rdy && !out_vld)
    else $error("in_rdy or out_vld high after reset");

  // New sop only once the previous packet closed
  a_sop_order: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld && out_rdy && out_sop |-> !in_pkt_r)
    else $error("out_sop without eop of previous packet");

endmodule

// ==== hdl/qs_top.sv ====
// Packet sorter top; no fixed latency and packets leave in arrival order
`timescale 1ns/1ps

module qs_top #(
  parameter int BANK_N = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_vld,
  input  logic        in_sop,
  input  logic        in_eop,
  input  qs_pkg::w_t  in_dat,
  output logic        in_rdy,
  output logic        out_vld,
  output logic        out_sop,
  output logic        out_eop,
  output qs_pkg::w_t  out_dat,
  input  logic        out_rdy
);

  // One bank port per stage
  qs_bank_if #(.BANK_N(BANK_N)) enq_bif ();
  qs_bank_if #(.BANK_N(BANK_N)) srt_bif ();

  // Producer
  qs_enq #(.BANK_N(BANK_N)) u_qs_enq (
    .in_vld (in_vld),
    .in_sop (in_sop),
    .in_eop (in_eop),
    .in_dat (in_dat),
    .in_rdy (in_rdy),
    .bif    (enq_bif.stage),
    .clk    (clk),
    .rst_n  (rst_n)
  );

  // Ping-pong buffer
  qs_banks #(.BANK_N(BANK_N)) u_qs_banks (
    .enq   (enq_bif.buffer),
    .srt   (srt_bif.buffer),
    .clk   (clk),
    .rst_n (rst_n)
  );

  // Consumer
  qs_sort_deq #(.BANK_N(BANK_N)) u_qs_sort_deq (
    .bif     (srt_bif.stage),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_dat (out_dat),
    .out_rdy (out_rdy),
    .clk     (clk),
    .rst_n   (rst_n)
  );

endmodule

// ==== hdl/qs_sort_deq.sv ====
// Bubble sort then drain in unsigned ascending order; latency grows with length squared
`timescale 1ns/1ps

module qs_sort_deq #(
  parameter int BANK_N = 8
) (
  qs_bank_if.stage    bif,
  output logic        out_vld,
  output logic        out_sop,
  output logic        out_eop,
  output qs_pkg::w_t  out_dat,
  input  logic        out_rdy,
  input  logic        clk,
  input  logic        rst_n
);

  localparam int AW = $clog2(BANK_N);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CMP,
    S_SWP_A,
    S_SWP_B,
    S_DRAIN,
    S_LAST
  } state_t;

  state_t                state_r;
  qs_bank_pkg::bank_id_t bank_idx_r;
  // Pair index while sorting
  logic [AW-1:0]         i_r;
  // Read index while draining
  logic [AW-1:0]         d_r;
  logic                  swapped_r;
  qs_pkg::w_t            hold_r;
  logic [AW-1:0]         i_nxt;
  logic                  pass_end;
  logic                  need_swap;
  logic                  slot_free;

  assign i_nxt     = i_r + 1'b1;
  assign pass_end  = (i_r == bif.cur_n);
  assign need_swap = (bif.rd_data_a > bif.rd_data_b);
  // Output register empty or being taken
  assign slot_free = !out_vld || out_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r    <= S_IDLE;
      bank_idx_r <= '0;
      i_r        <= '0;
      d_r        <= '0;
      swapped_r  <= 1'b0;
      out_vld    <= 1'b0;
      out_sop    <= 1'b0;
      out_eop    <= 1'b0;
    end else begin
      case (state_r)
        S_IDLE: begin
          if (bif.cur_status == qs_bank_pkg::BANK_READY) begin
            i_r       <= '0;
            swapped_r <= 1'b0;
            state_r   <= S_CMP;
          end
        end
        S_CMP: begin
          if (pass_end) begin
            // Every pass restarts at entry 0
            i_r       <= '0;
            swapped_r <= 1'b0;
            d_r       <= '0;
            if (!swapped_r) begin
              state_r <= S_DRAIN;
            end
          end else if (need_swap) begin
            state_r <= S_SWP_A;
          end else begin
            i_r <= i_nxt;
          end
        end
        S_SWP_A: state_r <= S_SWP_B;
        S_SWP_B: begin
          swapped_r <= 1'b1;
          i_r       <= i_nxt;
          state_r   <= S_CMP;
        end
        S_DRAIN: begin
          if (slot_free) begin
            out_vld <= 1'b1;
            out_sop <= (d_r == '0);
            out_eop <= (d_r == bif.cur_n);
            d_r     <= d_r + 1'b1;
            if (d_r == bif.cur_n) begin
              state_r <= S_LAST;
            end
          end
        end
        S_LAST: begin
          // eop beat frees the bank
          if (out_rdy) begin
            out_vld    <= 1'b0;
            bank_idx_r <= qs_bank_pkg::bank_id_inc(bank_idx_r);
            state_r    <= S_IDLE;
          end
        end
        default: state_r <= S_IDLE;
      endcase
    end
  end

  // Data registers
  always_ff @(posedge clk) begin
    if (state_r == S_CMP && !pass_end && need_swap) begin
      hold_r <= bif.rd_data_a;
    end
    if (state_r == S_DRAIN && slot_free) begin
      out_dat <= bif.rd_data_a;
    end
  end

  // Scoreboard updates
  always_comb begin
    bif.upd_vld    = 1'b0;
    bif.upd_status = qs_bank_pkg::BANK_SORTING;
    case (state_r)
      S_IDLE: begin
        bif.upd_vld = (bif.cur_status == qs_bank_pkg::BANK_READY);
      end
      S_CMP: begin
        // Clean pass ends the sort
        if (pass_end && !swapped_r) begin
          bif.upd_vld    = 1'b1;
          bif.upd_status = qs_bank_pkg::BANK_DRAINING;
        end
      end
      S_LAST: begin
        if (out_rdy) begin
          bif.upd_vld    = 1'b1;
          bif.upd_status = qs_bank_pkg::BANK_IDLE;
        end
      end
      default: ;
    endcase
  end

  assign bif.bank_idx  = bank_idx_r;
  assign bif.upd_n     = bif.cur_n;
  assign bif.rd_addr_a = (state_r == S_DRAIN) ? d_r : i_r;
  assign bif.rd_addr_b = i_nxt;
  // Swap in two writes with the lower entry first
  assign bif.wr_en     = (state_r == S_SWP_A) || (state_r == S_SWP_B);
  assign bif.wr_addr   = (state_r == S_SWP_A) ? i_r : i_nxt;
  // Upper entry still unchanged during the first write
  assign bif.wr_data   = (state_r == S_SWP_A) ? bif.rd_data_b : hold_r;

endmodule

// ==== hdl/qs_banks.sv ====
// Two-bank buffer and scoreboard; stages must never write the same bank in one cycle
`timescale 1ns/1ps

module qs_banks #(
  parameter int BANK_N = 8
) (
  qs_bank_if.buffer enq,
  qs_bank_if.buffer srt,
  input  logic      clk,
  input  logic      rst_n
);

  localparam int AW = $clog2(BANK_N);

  qs_pkg::w_t                mem_r    [2][BANK_N];
  qs_bank_pkg::bank_status_t status_r [2];
  logic [AW-1:0]             n_r      [2];
  qs_bank_pkg::bank_state_t  enq_req;
  qs_bank_pkg::bank_state_t  srt_req;

  always_comb begin
    enq_req.vld    = enq.upd_vld;
    enq_req.status = enq.upd_status;
    srt_req.vld    = srt.upd_vld;
    srt_req.status = srt.upd_status;
  end

  // Word memories written by whichever stage selects the bank
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (srt.wr_en && srt.bank_idx == qs_bank_pkg::bank_id_t'(b)) begin
        mem_r[b][srt.wr_addr] <= srt.wr_data;
      end else if (enq.wr_en && enq.bank_idx == qs_bank_pkg::bank_id_t'(b)) begin
        mem_r[b][enq.wr_addr] <= enq.wr_data;
      end
    end
  end

  // Scoreboard of status and last index per bank
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        status_r[b] <= qs_bank_pkg::BANK_IDLE;
        n_r[b]      <= '0;
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (srt_req.vld && srt.bank_idx == qs_bank_pkg::bank_id_t'(b)) begin
          status_r[b] <= srt_req.status;
          n_r[b]      <= srt.upd_n;
        end else if (enq_req.vld && enq.bank_idx == qs_bank_pkg::bank_id_t'(b)) begin
          status_r[b] <= enq_req.status;
          n_r[b]      <= enq.upd_n;
        end
      end
    end
  end

  // Entry and reads of the selected bank
  assign enq.cur_status = status_r[enq.bank_idx];
  assign enq.cur_n      = n_r[enq.bank_idx];
  assign enq.rd_data_a  = mem_r[enq.bank_idx][enq.rd_addr_a];
  assign enq.rd_data_b  = mem_r[enq.bank_idx][enq.rd_addr_b];
  assign srt.cur_status = status_r[srt.bank_idx];
  assign srt.cur_n      = n_r[srt.bank_idx];
  assign srt.rd_data_a  = mem_r[srt.bank_idx][srt.rd_addr_a];
  assign srt.rd_data_b  = mem_r[srt.bank_idx][srt.rd_addr_b];

endmodule

// ==== hdl/qs_enq.sv ====
// Enqueue stage; packets over BANK_N words overwrite the last entry and sop restarts at 0
`timescale 1ns/1ps

module qs_enq #(
  parameter int BANK_N = 8
) (
  input  logic        in_vld,
  input  logic        in_sop,
  input  logic        in_eop,
  input  qs_pkg::w_t  in_dat,
  output logic        in_rdy,
  qs_bank_if.stage    bif,
  input  logic        clk,
  input  logic        rst_n
);

  localparam int AW = $clog2(BANK_N);

  // Bit 2 of the encoding is the ready flag
  typedef enum logic [2:0] {
    E_IDLE       = 3'b000,
    E_LOAD       = 3'b101,
    E_UPDATE_IDX = 3'b001
  } state_t;

  state_t                state_r;
  qs_bank_pkg::bank_id_t bank_idx_r;
  logic [AW-1:0]         wr_ptr_r;
  logic                  wr_en_r;
  logic [AW-1:0]         wr_addr_r;
  qs_pkg::w_t            wr_data_r;
  logic                  accept;
  logic [AW-1:0]         wr_addr;

  assign in_rdy = state_r[2];
  assign accept = in_vld && in_rdy;
  // First word of a packet always lands at entry 0
  assign wr_addr = in_sop ? '0 : wr_ptr_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r    <= E_IDLE;
      bank_idx_r <= '0;
      wr_en_r    <= 1'b0;
    end else begin
      wr_en_r <= accept;
      case (state_r)
        E_IDLE: begin
          // Claim the selected bank once it is free
          if (bif.cur_status == qs_bank_pkg::BANK_IDLE) begin
            state_r <= E_LOAD;
          end
        end
        E_LOAD: begin
          if (accept && in_eop) begin
            state_r <= E_UPDATE_IDX;
          end
        end
        E_UPDATE_IDX: begin
          // Last write leaves the output flop this cycle
          bank_idx_r <= qs_bank_pkg::bank_id_inc(bank_idx_r);
          state_r    <= E_IDLE;
        end
        default: state_r <= E_IDLE;
      endcase
    end
  end

  // Write pointer and registered write command
  always_ff @(posedge clk) begin
    if (state_r == E_IDLE) begin
      wr_ptr_r <= '0;
    end else if (accept) begin
      // Saturate on the last entry
      if (wr_addr != AW'(BANK_N - 1)) begin
        wr_ptr_r <= wr_addr + 1'b1;
      end else begin
        wr_ptr_r <= wr_addr;
      end
    end
    if (accept) begin
      wr_addr_r <= wr_addr;
      wr_data_r <= in_dat;
    end
  end

  // Scoreboard updates
  always_comb begin
    bif.upd_vld    = 1'b0;
    bif.upd_status = qs_bank_pkg::BANK_LOADING;
    bif.upd_n      = wr_addr;
    case (state_r)
      E_IDLE: begin
        if (bif.cur_status == qs_bank_pkg::BANK_IDLE) begin
          bif.upd_vld = 1'b1;
          bif.upd_n   = '0;
        end
      end
      E_LOAD: begin
        // Count is the index of the eop word
        if (accept && in_eop) begin
          bif.upd_vld    = 1'b1;
          bif.upd_status = qs_bank_pkg::BANK_READY;
        end
      end
      default: ;
    endcase
  end

  assign bif.bank_idx  = bank_idx_r;
  assign bif.wr_en     = wr_en_r;
  assign bif.wr_addr   = wr_addr_r;
  assign bif.wr_data   = wr_data_r;
  // Producer never reads back
  assign bif.rd_addr_a = '0;
  assign bif.rd_addr_b = '0;

endmodule

// ==== hdl/qs_bank_if.sv ====
// One stage's port onto the bank block; BANK_N must be at least 2
`timescale 1ns/1ps

interface qs_bank_if #(
  parameter int BANK_N = 8
);

  localparam int AW = $clog2(BANK_N);

  // Bank chosen by the stage
  qs_bank_pkg::bank_id_t     bank_idx;
  // Synchronous write port
  logic                      wr_en;
  logic [AW-1:0]             wr_addr;
  qs_pkg::w_t                wr_data;
  // Two asynchronous read ports
  logic [AW-1:0]             rd_addr_a;
  logic [AW-1:0]             rd_addr_b;
  qs_pkg::w_t                rd_data_a;
  qs_pkg::w_t                rd_data_b;
  // Scoreboard update for bank_idx only
  logic                      upd_vld;
  qs_bank_pkg::bank_status_t upd_status;
  logic [AW-1:0]             upd_n;
  // Scoreboard entry of bank_idx
  qs_bank_pkg::bank_status_t cur_status;
  logic [AW-1:0]             cur_n;

  modport stage (
    output bank_idx, wr_en, wr_addr, wr_data, rd_addr_a, rd_addr_b,
    output upd_vld, upd_status, upd_n,
    input  cur_status, cur_n, rd_data_a, rd_data_b
  );

  modport buffer (
    input  bank_idx, wr_en, wr_addr, wr_data, rd_addr_a, rd_addr_b,
    input  upd_vld, upd_status, upd_n,
    output cur_status, cur_n, rd_data_a, rd_data_b
  );

endinterface

// ==== hdl/qs_bank_pkg.sv ====
// Bank bookkeeping types for exactly two banks; bank counts are sized per module
package qs_bank_pkg;

  // Bank index for two banks
  typedef logic bank_id_t;

  // Life cycle of one bank
  typedef enum logic [2:0] {
    BANK_IDLE     = 3'd0,
    BANK_LOADING  = 3'd1,
    BANK_READY    = 3'd2,
    BANK_SORTING  = 3'd3,
    BANK_DRAINING = 3'd4
  } bank_status_t;

  // Requested state change for one bank
  typedef struct packed {
    logic         vld;
    bank_status_t status;
  } bank_state_t;

  // Ping-pong step to the other bank
  function automatic bank_id_t bank_id_inc(bank_id_t id);
    return bank_id_t'(id + 1'b1);
  endfunction

endpackage

// ==== hdl/qs_pkg.sv ====
// Datapath word type; words are treated as unsigned by the sorter
package qs_pkg;

  // Data word width in bits
  parameter int W = 16;

  // One data word
  typedef logic [W-1:0] w_t;

endpackage
